// File: run_sim.sh
#!/bin/sh
# Build and run the SD command engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sd_cmd_top.f --top-module tb_sd_cmd_top -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "=== PASS ==="; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: sd_card_model.sv
`timescale 1ns/1ps
`include "sd_settings.svh"

module sd_card_model (
  input  logic                             i_clk,
  input  logic                             i_rst_n,
  input  logic                             i_cmd_line,  // Host side of CMD
  input  logic                             i_cmd_oe,
  input  sd_proto_pkg::cmd_index_t         i_resp_index,
  input  sd_proto_pkg::cmd_arg_t           i_resp_content,
  input  logic                             i_corrupt_crc,
  input  logic                             i_silent,
  input  int                               i_delay,
  output logic                             o_cmd_line,
  output logic [`SD_FRAME_BITS-1:0]        o_frame,      // Last captured command
  output logic [`SD_CRC7_BITS-1:0]         o_frame_crc,  // CRC recomputed over it
  output int                               o_frame_cnt
);

  typedef enum logic [1:0] {
    LISTEN,
    HOLD,   // Response delay
    TALK
  } card_state_e;

  card_state_e               state;
  logic [`SD_FRAME_BITS-1:0] cap_sr;
  logic [`SD_FRAME_BITS-1:0] resp_sr;
  int                        bit_cnt;
  int                        wait_cnt;

  // x^7 + x^3 + 1, MSB first
  function automatic logic [6:0] crc7_of(input logic [`SD_PAYLOAD_BITS-1:0] bits);
    logic [6:0] c;
    logic       fb;
    c = '0;
    for (int i = `SD_PAYLOAD_BITS - 1; i >= 0; i--) begin
      fb = c[6] ^ bits[i];
      c  = {c[5:0], 1'b0};
      if (fb) c = c ^ 7'h09;
    end
    return c;
  endfunction

  // Start, card bit, index, content, CRC, stop
  function automatic logic [`SD_FRAME_BITS-1:0] build_resp(
    input sd_proto_pkg::cmd_index_t index,
    input sd_proto_pkg::cmd_arg_t   content,
    input logic                     corrupt
  );
    logic [`SD_PAYLOAD_BITS-1:0] head;
    logic [6:0]                  crc;
    head = {2'b00, index, content};
    crc  = crc7_of(head);
    if (corrupt) crc[0] = ~crc[0];  // Frame bit 1
    return {head, crc, 1'b1};
  endfunction

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state       <= LISTEN;
      cap_sr      <= '1;
      resp_sr     <= '1;
      bit_cnt     <= 0;
      wait_cnt    <= 0;
      o_cmd_line  <= 1'b1;  // Line idles high
      o_frame     <= '0;
      o_frame_crc <= '0;
      o_frame_cnt <= 0;
    end else begin
      case (state)
        LISTEN: begin
          if (i_cmd_oe) begin
            cap_sr <= {cap_sr[`SD_FRAME_BITS-2:0], i_cmd_line};
            if (bit_cnt == `SD_FRAME_BITS - 1) begin
              bit_cnt     <= 0;
              o_frame     <= {cap_sr[`SD_FRAME_BITS-2:0], i_cmd_line};
              o_frame_crc <= crc7_of(cap_sr[`SD_FRAME_BITS-2:`SD_CRC7_BITS]);
              o_frame_cnt <= o_frame_cnt + 1;
              if (!i_silent) begin
                state    <= HOLD;
                wait_cnt <= i_delay;
                resp_sr  <= build_resp(i_resp_index, i_resp_content, i_corrupt_crc);
              end
            end else begin
              bit_cnt <= bit_cnt + 1;
            end
          end
        end
        HOLD: begin
          if (wait_cnt == 0) begin
            o_cmd_line <= resp_sr[`SD_FRAME_BITS-1];  // Start bit
            resp_sr    <= {resp_sr[`SD_FRAME_BITS-2:0], 1'b1};
            bit_cnt    <= `SD_FRAME_BITS - 1;
            state      <= TALK;
          end else begin
            wait_cnt <= wait_cnt - 1;
          end
        end
        TALK: begin
          if (bit_cnt == 0) begin
            o_cmd_line <= 1'b1;
            state      <= LISTEN;
          end else begin
            o_cmd_line <= resp_sr[`SD_FRAME_BITS-1];
            resp_sr    <= {resp_sr[`SD_FRAME_BITS-2:0], 1'b1};
            bit_cnt    <= bit_cnt - 1;
          end
        end
        default: state <= LISTEN;
      endcase
    end
  end

endmodule

// File: sd_cmd_ctrl.sv
`timescale 1ns/1ps

module sd_cmd_ctrl (
  input  logic                     CLK,
  input  logic                     i_rst_n,
  // Host side
  input  logic                     i_cmd_valid,
  input  sd_proto_pkg::cmd_index_t i_cmd_index,
  input  sd_proto_pkg::cmd_arg_t   i_cmd_arg,
  output logic                     o_cmd_ready,
  // Transmitter
  output logic                     o_tx_start,
  output sd_proto_pkg::cmd_index_t o_tx_index,
  output sd_proto_pkg::cmd_arg_t   o_tx_arg,
  input  logic                     i_tx_done,
  // Receiver
  output logic                     o_rx_arm,
  input  logic                     i_resp_valid,
  input  logic                     i_timeout,
  input  sd_proto_pkg::cmd_index_t i_resp_index,
  input  sd_proto_pkg::cmd_arg_t   i_resp_content,
  input  logic                     i_crc_ok,
  // Completion
  output logic                     o_done,
  output sd_ctrl_pkg::sd_err_e     o_error_code,
  output sd_proto_pkg::cmd_arg_t   o_resp_content,
  output logic                     o_acmd
);

  sd_ctrl_pkg::ctrl_state_e state_q;
  sd_proto_pkg::cmd_index_t cmd_index_q;
  sd_proto_pkg::cmd_arg_t   cmd_arg_q;
  sd_proto_pkg::opcode_e    opcode_q;
  sd_proto_pkg::cmd_ctrl_t  ctrl;
  logic                     accept;
  logic                     finish;
  logic                     check_frame;
  sd_ctrl_pkg::sd_err_e     err_d;

  assign o_cmd_ready = (state_q == sd_ctrl_pkg::IDLE);
  assign accept      = i_cmd_valid && o_cmd_ready;
  assign o_tx_index  = cmd_index_q;
  assign o_tx_arg    = cmd_arg_q;

  assign ctrl        = sd_proto_pkg::lookup_ctrl(opcode_q);
  assign check_frame = (ctrl.rtype != sd_proto_pkg::R3_OCR);  // OCR carries no valid CRC/index

  // Receiver starts listening as the stop bit leaves
  assign o_rx_arm = (state_q == sd_ctrl_pkg::SEND) && i_tx_done &&
                    (ctrl.rtype != sd_proto_pkg::R0_NONE);

  //////////////////////////////////////////////////////////////////////
  // Completion and error priority
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    finish = 1'b0;
    err_d  = sd_ctrl_pkg::ERR_NONE;
    case (state_q)
      sd_ctrl_pkg::SEND: begin
        finish = i_tx_done && (ctrl.rtype == sd_proto_pkg::R0_NONE);
      end
      sd_ctrl_pkg::RECV: begin
        finish = i_resp_valid || i_timeout;
        if (i_timeout) begin
          err_d = sd_ctrl_pkg::ERR_TIMEOUT;
        end else if (check_frame && !i_crc_ok) begin
          err_d = sd_ctrl_pkg::ERR_CRC;
        end else if (check_frame && (i_resp_index != cmd_index_q)) begin
          err_d = sd_ctrl_pkg::ERR_INDEX;
        end else if ((i_resp_content & ctrl.redo_mask) != ctrl.redo_ans) begin
          err_d = sd_ctrl_pkg::ERR_REDO;  // Card still busy, host should retry
        end else if ((i_resp_content & ctrl.err_mask) != ctrl.err_ans) begin
          err_d = sd_ctrl_pkg::ERR_STATUS;
        end
      end
      default: begin
        finish = 1'b0;
      end
    endcase
  end

  // FSM and completion outputs
  always_ff @(posedge CLK or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q      <= sd_ctrl_pkg::IDLE;
      o_tx_start   <= 1'b0;
      o_done       <= 1'b0;
      o_error_code <= sd_ctrl_pkg::ERR_NONE;
      o_acmd       <= 1'b0;
    end else begin
      o_tx_start <= 1'b0;
      o_done     <= 1'b0;
      case (state_q)
        sd_ctrl_pkg::IDLE: begin
          if (accept) begin
            state_q    <= sd_ctrl_pkg::SEND;
            o_tx_start <= 1'b1;
          end
        end
        sd_ctrl_pkg::SEND: begin
          if (finish) begin
            state_q <= sd_ctrl_pkg::DONE;  // No response expected
          end else if (i_tx_done) begin
            state_q <= sd_ctrl_pkg::RECV;
          end
        end
        sd_ctrl_pkg::RECV: begin
          if (finish) begin
            state_q <= sd_ctrl_pkg::DONE;
          end
        end
        default: state_q <= sd_ctrl_pkg::IDLE;
      endcase
      if (finish) begin
        o_done       <= 1'b1;
        o_error_code <= err_d;
        // Next command is an ACMD only after a clean CMD55
        o_acmd       <= (opcode_q == sd_proto_pkg::CMD55) && (err_d == sd_ctrl_pkg::ERR_NONE);
      end
    end
  end

  // Command latch and response content
  always_ff @(posedge CLK) begin
    if (accept) begin
      cmd_index_q <= i_cmd_index;
      cmd_arg_q   <= i_cmd_arg;
      opcode_q    <= sd_proto_pkg::opcode_e'({o_acmd, i_cmd_index});
    end
    if (finish) begin
      o_resp_content <= (state_q == sd_ctrl_pkg::RECV) ? i_resp_content : '0;
    end
  end

  // Receiver results only land while a response is awaited
  assert property (@(posedge CLK) disable iff (!i_rst_n)
                   (i_resp_valid || i_timeout) |-> (state_q == sd_ctrl_pkg::RECV));

endmodule

// File: sd_cmd_top.f
+incdir+.
sd_proto_pkg.sv
sd_ctrl_pkg.sv
sd_cmd_tx.sv
sd_resp_rx.sv
sd_cmd_ctrl.sv
sd_cmd_top.sv
sd_card_model.sv
tb_sd_cmd_top.sv

// File: sd_cmd_top.sv
`timescale 1ns/1ps

module sd_cmd_top (
  input  logic                     CLK,
  input  logic                     i_rst_n,
  // Host command port
  input  logic                     i_cmd_valid,
  input  sd_proto_pkg::cmd_index_t i_cmd_index,
  input  sd_proto_pkg::cmd_arg_t   i_cmd_arg,
  output logic                     o_cmd_ready,
  // Card CMD line
  input  logic                     i_sd_cmd,
  output logic                     o_sd_cmd,
  output logic                     o_sd_cmd_oe,
  // Completion
  output logic                     o_done,
  output sd_ctrl_pkg::sd_err_e     o_error_code,
  output sd_proto_pkg::cmd_arg_t   o_resp_content,
  output logic                     o_acmd
);

  logic                     w_tx_start;
  sd_proto_pkg::cmd_index_t w_tx_index;
  sd_proto_pkg::cmd_arg_t   w_tx_arg;
  logic                     w_tx_done;
  logic                     w_rx_arm;
  logic                     w_resp_valid;
  logic                     w_timeout;
  sd_proto_pkg::cmd_index_t w_resp_index;
  sd_proto_pkg::cmd_arg_t   w_resp_content;
  logic                     w_crc_ok;

  sd_cmd_ctrl u_ctrl (
    .CLK(CLK), .i_rst_n(i_rst_n),
    .i_cmd_valid(i_cmd_valid), .i_cmd_index(i_cmd_index), .i_cmd_arg(i_cmd_arg),
    .o_cmd_ready(o_cmd_ready),
    .o_tx_start(w_tx_start), .o_tx_index(w_tx_index), .o_tx_arg(w_tx_arg),
    .i_tx_done(w_tx_done),
    .o_rx_arm(w_rx_arm), .i_resp_valid(w_resp_valid), .i_timeout(w_timeout),
    .i_resp_index(w_resp_index), .i_resp_content(w_resp_content), .i_crc_ok(w_crc_ok),
    .o_done(o_done), .o_error_code(o_error_code), .o_resp_content(o_resp_content),
    .o_acmd(o_acmd)
  );

  sd_cmd_tx u_tx (
    .CLK(CLK), .i_rst_n(i_rst_n),
    .i_start(w_tx_start), .i_index(w_tx_index), .i_arg(w_tx_arg),
    .o_sd_cmd(o_sd_cmd), .o_sd_cmd_oe(o_sd_cmd_oe), .o_tx_done(w_tx_done)
  );

  sd_resp_rx u_rx (
    .CLK(CLK), .i_rst_n(i_rst_n),
    .i_arm(w_rx_arm), .i_sd_cmd(i_sd_cmd),
    .o_resp_valid(w_resp_valid), .o_timeout(w_timeout),
    .o_resp_index(w_resp_index), .o_resp_content(w_resp_content), .o_crc_ok(w_crc_ok)
  );

endmodule

// File: sd_cmd_tx.sv
`timescale 1ns/1ps
`include "sd_settings.svh"

module sd_cmd_tx (
  input  logic                     CLK,
  input  logic                     i_rst_n,
  input  logic                     i_start,
  input  sd_proto_pkg::cmd_index_t i_index,
  input  sd_proto_pkg::cmd_arg_t   i_arg,
  output logic                     o_sd_cmd,
  output logic                     o_sd_cmd_oe,
  output logic                     o_tx_done
);

  typedef logic [$clog2(`SD_FRAME_BITS)-1:0] bit_cnt_t;

  bit_cnt_t                    bit_cnt_q;  // Frame position now on the line
  logic [`SD_PAYLOAD_BITS-2:0] head_q;     // Head bits behind the start bit
  logic [`SD_CRC7_BITS:0]      tail_q;
  logic [`SD_CRC7_BITS-1:0]    crc_q;
  logic [`SD_CRC7_BITS-1:0]    crc_next;
  logic                        in_head;
  logic                        last_head;

  // CRC takes the bit that is on the line this cycle
  assign crc_next  = sd_proto_pkg::crc7_step(crc_q, o_sd_cmd);
  assign in_head   = (bit_cnt_q < bit_cnt_t'(`SD_PAYLOAD_BITS - 1));
  assign last_head = (bit_cnt_q == bit_cnt_t'(`SD_PAYLOAD_BITS - 1));

  //////////////////////////////////////////////////////////////////////
  // Line driver
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge i_rst_n) begin
    if (!i_rst_n) begin
      bit_cnt_q   <= '0;
      o_sd_cmd    <= 1'b1;  // CMD idles high
      o_sd_cmd_oe <= 1'b0;
      o_tx_done   <= 1'b0;
    end else begin
      o_tx_done <= 1'b0;
      if (i_start) begin
        bit_cnt_q   <= '0;
        o_sd_cmd    <= 1'b0;  // Start bit
        o_sd_cmd_oe <= 1'b1;
      end else if (o_sd_cmd_oe) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
        if (in_head) begin
          o_sd_cmd <= head_q[`SD_PAYLOAD_BITS-2];
        end else if (last_head) begin
          o_sd_cmd <= crc_next[`SD_CRC7_BITS-1];  // CRC MSB follows the argument
        end else if (bit_cnt_q != bit_cnt_t'(`SD_FRAME_BITS - 1)) begin
          o_sd_cmd <= tail_q[`SD_CRC7_BITS];
        end else begin
          // Stop bit has had its cycle
          o_sd_cmd    <= 1'b1;
          o_sd_cmd_oe <= 1'b0;
          o_tx_done   <= 1'b1;
        end
      end
    end
  end

  // Head and tail shifters
  always_ff @(posedge CLK) begin
    if (i_start) begin
      head_q <= {1'b1, i_index, i_arg};  // Transmitter bit first
      crc_q  <= '0;
    end else if (o_sd_cmd_oe) begin
      if (in_head) begin
        head_q <= {head_q[`SD_PAYLOAD_BITS-3:0], 1'b0};
        crc_q  <= crc_next;
      end else if (last_head) begin
        tail_q <= {crc_next[`SD_CRC7_BITS-2:0], 2'b11};  // Low CRC bits, stop, idle
      end else begin
        tail_q <= {tail_q[`SD_CRC7_BITS-1:0], 1'b1};
      end
    end
  end

  // Controller waits for tx_done before the next start
  assert property (@(posedge CLK) disable iff (!i_rst_n) i_start |-> !o_sd_cmd_oe);

endmodule

// File: sd_ctrl_pkg.sv
package sd_ctrl_pkg;

  // Command sequencing
  typedef enum logic [1:0] {
    IDLE,
    SEND,  // Frame going out on CMD
    RECV,  // Waiting for the card
    DONE
  } ctrl_state_e;

  // Reported once per command, lowest value wins on overlap
  typedef enum logic [2:0] {
    ERR_NONE    = 3'd0,
    ERR_TIMEOUT = 3'd1,
    ERR_CRC     = 3'd2,
    ERR_INDEX   = 3'd3,
    ERR_REDO    = 3'd4,
    ERR_STATUS  = 3'd5
  } sd_err_e;

endpackage

// File: sd_proto_pkg.sv
package sd_proto_pkg;

  typedef logic [5:0]  cmd_index_t;
  typedef logic [31:0] cmd_arg_t;  // Argument or response content

  // Bit 6 is the ACMD flag, the index sits below it
  typedef enum logic [6:0] {
    CMD0   = 7'd0,
    CMD3   = 7'd3,
    CMD6   = 7'd6,
    CMD7   = 7'd7,
    CMD8   = 7'd8,
    CMD17  = 7'd17,
    CMD55  = 7'd55,
    ACMD6  = 7'd70,
    ACMD41 = 7'd105,
    ACMD55 = 7'd119
  } opcode_e;

  typedef enum logic [2:0] {
    R0_NONE   = 3'd0,
    R1_NORMAL = 3'd1,
    R3_OCR    = 3'd3,
    R6_RCA    = 3'd6,
    R7_CIC    = 3'd7
  } resp_type_e;

  typedef struct packed {
    resp_type_e rtype;
    cmd_arg_t   redo_mask;  // Status bits that ask for a retry
    cmd_arg_t   redo_ans;
    cmd_arg_t   err_mask;   // Status bits that flag an error
    cmd_arg_t   err_ans;
  } cmd_ctrl_t;

  // Per-opcode response type and status masks
  function automatic cmd_ctrl_t lookup_ctrl(opcode_e op);
    case (op)
      CMD0:    return '{R0_NONE,   32'h0,        32'h0,        32'h0,        32'h0};
      CMD3:    return '{R6_RCA,    32'h0,        32'h0,        32'h00002000, 32'h0};
      CMD6:    return '{R1_NORMAL, 32'h0,        32'h0,        32'h82380000, 32'h0};
      ACMD6:   return '{R1_NORMAL, 32'h0,        32'h0,        32'h8F398020, 32'h00000020};
      CMD7:    return '{R1_NORMAL, 32'h0,        32'h0,        32'h0F398000, 32'h0};
      CMD8:    return '{R7_CIC,    32'h0,        32'h0,        32'h00000FFF, 32'h000001FF};
      CMD17:   return '{R1_NORMAL, 32'h0,        32'h0,        32'hCF398000, 32'h0};
      ACMD41:  return '{R3_OCR,    32'h80000000, 32'h80000000, 32'h41FF8000, 32'h40FF8000};
      CMD55:   return '{R1_NORMAL, 32'h0,        32'h0,        32'h0F398000, 32'h0};
      default: return '{R1_NORMAL, 32'h0,        32'h0,        32'h0F398000, 32'h0};  // ACMD55
    endcase
  endfunction

  // One serial step of x^7 + x^3 + 1
  function automatic logic [6:0] crc7_step(logic [6:0] crc, logic din);
    logic fb;
    fb = crc[6] ^ din;
    return {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
  endfunction

endpackage

// File: sd_resp_rx.sv
`timescale 1ns/1ps
`include "sd_settings.svh"

module sd_resp_rx (
  input  logic                     CLK,
  input  logic                     i_rst_n,
  input  logic                     i_arm,  // Pulse once the command frame is out
  input  logic                     i_sd_cmd,
  output logic                     o_resp_valid,
  output logic                     o_timeout,
  output sd_proto_pkg::cmd_index_t o_resp_index,
  output sd_proto_pkg::cmd_arg_t   o_resp_content,
  output logic                     o_crc_ok
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_WAIT,   // Hunting for the start bit
    RX_SHIFT
  } rx_state_e;

  typedef logic [$clog2(`SD_FRAME_BITS)-1:0] bit_cnt_t;
  typedef logic [$clog2(`SD_NCR_MAX)-1:0]    ncr_cnt_t;

  rx_state_e                 state_q;
  bit_cnt_t                  bit_cnt_q;  // Bits captured so far
  ncr_cnt_t                  ncr_cnt_q;  // Cycles left before timeout
  logic [`SD_FRAME_BITS-1:0] sr_q;
  logic [`SD_CRC7_BITS-1:0]  crc_q;
  logic                      sample;

  // Start bit seen or already inside the frame
  assign sample = (state_q == RX_SHIFT) || ((state_q == RX_WAIT) && !i_sd_cmd);

  always_ff @(posedge CLK or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q      <= RX_IDLE;
      bit_cnt_q    <= '0;
      ncr_cnt_q    <= '0;
      o_resp_valid <= 1'b0;
      o_timeout    <= 1'b0;
    end else begin
      o_resp_valid <= 1'b0;
      o_timeout    <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          if (i_arm) begin
            state_q   <= RX_WAIT;
            ncr_cnt_q <= ncr_cnt_t'(`SD_NCR_MAX - 1);
          end
        end
        RX_WAIT: begin
          if (!i_sd_cmd) begin
            state_q   <= RX_SHIFT;
            bit_cnt_q <= bit_cnt_t'(1);
          end else if (ncr_cnt_q == '0) begin
            state_q   <= RX_IDLE;  // Card never answered
            o_timeout <= 1'b1;
          end else begin
            ncr_cnt_q <= ncr_cnt_q - 1'b1;
          end
        end
        RX_SHIFT: begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
          if (bit_cnt_q == bit_cnt_t'(`SD_FRAME_BITS - 1)) begin
            state_q      <= RX_IDLE;
            o_resp_valid <= 1'b1;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Deserializer and CRC over the leading 40 bits
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (sample) begin
      sr_q <= {sr_q[`SD_FRAME_BITS-2:0], i_sd_cmd};
      if (state_q == RX_WAIT) begin
        crc_q <= sd_proto_pkg::crc7_step('0, i_sd_cmd);  // Fresh CRC from the start bit
      end else if (bit_cnt_q < bit_cnt_t'(`SD_PAYLOAD_BITS)) begin
        crc_q <= sd_proto_pkg::crc7_step(crc_q, i_sd_cmd);
      end
    end
  end

  assign o_resp_index   = sr_q[`SD_FRAME_BITS-3:`SD_FRAME_BITS-8];
  assign o_resp_content = sr_q[`SD_PAYLOAD_BITS-1:`SD_CRC7_BITS+1];
  assign o_crc_ok       = (crc_q == sr_q[`SD_CRC7_BITS:1]);  // Bits 7..1 hold the card's CRC

  // Controller arms only an idle receiver
  assert property (@(posedge CLK) disable iff (!i_rst_n) i_arm |-> (state_q == RX_IDLE));

endmodule

// File: sd_settings.svh
`ifndef SD_SETTINGS_SVH
`define SD_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// CMD line frame geometry
//////////////////////////////////////////////////////////////////////

// Start, transmitter bit, index, argument, CRC7 and stop bit
`define SD_FRAME_BITS 48

`define SD_CRC7_BITS 7

// Leading part of the frame that the CRC7 covers
`define SD_PAYLOAD_BITS 40

//////////////////////////////////////////////////////////////////////
// Response timing
//////////////////////////////////////////////////////////////////////

// Max cycles from command end to the response start bit
`define SD_NCR_MAX 64

`endif

// File: tb_sd_cmd_top.sv
`timescale 1ns/1ps
`include "sd_settings.svh"

module tb_sd_cmd_top;

  localparam int NUM_ROWS   = 17;
  localparam int DONE_WAIT  = `SD_NCR_MAX + 120;
  localparam int READY_WAIT = 8;

  typedef struct packed {
    sd_proto_pkg::cmd_index_t index;
    sd_proto_pkg::cmd_arg_t   arg;
    sd_proto_pkg::cmd_index_t resp_index;
    sd_proto_pkg::cmd_arg_t   resp_content;
    logic                     corrupt;
    logic                     silent;
    int                       delay;     // -1 picks a random delay
    sd_ctrl_pkg::sd_err_e     exp_err;
    logic                     exp_acmd;
  } stim_row_t;

  // index, arg, resp index, resp content, corrupt, silent, delay, error, acmd
  stim_row_t rows [NUM_ROWS] = '{
    '{6'd0,  32'h00000000, 6'd0,  32'h00000000, 1'b0, 1'b1, 0, sd_ctrl_pkg::ERR_NONE, 1'b0},
    '{6'd8,  32'h000001AA, 6'd8,  32'h000001FF, 1'b0, 1'b0, -1, sd_ctrl_pkg::ERR_NONE, 1'b0},
    '{6'd55, 32'h00000000, 6'd55, 32'h00000120, 1'b0, 1'b0, 0, sd_ctrl_pkg::ERR_NONE, 1'b1},
    '{6'd41, 32'h40FF8000, 6'h3F, 32'h00FF8000, 1'b0, 1'b0, -1, sd_ctrl_pkg::ERR_REDO, 1'b0},
    '{6'd55, 32'h00000000, 6'd55, 32'h00000120, 1'b0, 1'b0, -1, sd_ctrl_pkg::ERR_NONE, 1'b1},
    '{6'd41, 32'h40FF8000, 6'h3F, 32'hC0FF8000, 1'b1, 1'b0, 63, sd_ctrl_pkg::ERR_NONE, 1'b0},
    '{6'd41, 32'h40FF8000, 6'd41, 32'h00000900, 1'b0, 1'b0, -1, sd_ctrl_pkg::ERR_NONE, 1'b0},
    '{6'd3,  32'h00000000, 6'd3,  32'h12340500, 1'b0, 1'b0, -1, sd_ctrl_pkg::ERR_NONE, 1'b0},
    '{6'd7,  32'h12340000, 6'd7,  32'h00000700, 1'b0, 1'b0, -1, sd_ctrl_pkg::ERR_NONE, 1'b0},
    '{6'd7,  32'h12340000, 6'd7,  32'h00080000, 1'b0, 1'b0, -1, sd_ctrl_pkg::ERR_STATUS, 1'b0},
    '{6'd17, 32'h00000200, 6'd17, 32'h00000900, 1'b1, 1'b0, -1, sd_ctrl_pkg::ERR_CRC, 1'b0},
    '{6'd17, 32'h00000200, 6'd18, 32'h00000900, 1'b0, 1'b0, -1, sd_ctrl_pkg::ERR_INDEX, 1'b0},
    '{6'd17, 32'h00000200, 6'd17, 32'h00000900, 1'b0, 1'b1, 0, sd_ctrl_pkg::ERR_TIMEOUT, 1'b0},
    '{6'd55, 32'h00000000, 6'd55, 32'h00000120, 1'b1, 1'b0, -1, sd_ctrl_pkg::ERR_CRC, 1'b0},
    '{6'd55, 32'h00000000, 6'd55, 32'h00000120, 1'b0, 1'b0, -1, sd_ctrl_pkg::ERR_NONE, 1'b1},
    '{6'd6,  32'h00000002, 6'd6,  32'h00000900, 1'b0, 1'b0, -1, sd_ctrl_pkg::ERR_STATUS, 1'b0},
    '{6'd6,  32'h00000002, 6'd6,  32'h00000900, 1'b0, 1'b0, -1, sd_ctrl_pkg::ERR_NONE, 1'b0}
  };

  logic                     clk;
  logic                     rst_n;
  logic                     cmd_valid;
  sd_proto_pkg::cmd_index_t cmd_index;
  sd_proto_pkg::cmd_arg_t   cmd_arg;
  logic                     cmd_ready;
  logic                     sd_cmd_in;
  logic                     sd_cmd_out;
  logic                     sd_cmd_oe;
  logic                     done;
  sd_ctrl_pkg::sd_err_e     error_code;
  sd_proto_pkg::cmd_arg_t   resp_content;
  logic                     acmd;

  // Card configuration and what it saw
  sd_proto_pkg::cmd_index_t  card_index;
  sd_proto_pkg::cmd_arg_t    card_content;
  logic                      card_corrupt;
  logic                      card_silent;
  int                        card_delay;
  logic [`SD_FRAME_BITS-1:0] frame;
  logic [`SD_CRC7_BITS-1:0]  frame_crc;
  int                        frame_cnt;

  int seed      = 62514;
  int err_count = 0;

  sd_cmd_top u_dut (
    .CLK(clk), .i_rst_n(rst_n),
    .i_cmd_valid(cmd_valid), .i_cmd_index(cmd_index), .i_cmd_arg(cmd_arg),
    .o_cmd_ready(cmd_ready),
    .i_sd_cmd(sd_cmd_in), .o_sd_cmd(sd_cmd_out), .o_sd_cmd_oe(sd_cmd_oe),
    .o_done(done), .o_error_code(error_code), .o_resp_content(resp_content),
    .o_acmd(acmd)
  );

  sd_card_model u_card (
    .i_clk(clk), .i_rst_n(rst_n),
    .i_cmd_line(sd_cmd_out), .i_cmd_oe(sd_cmd_oe),
    .i_resp_index(card_index), .i_resp_content(card_content),
    .i_corrupt_crc(card_corrupt), .i_silent(card_silent), .i_delay(card_delay),
    .o_cmd_line(sd_cmd_in),
    .o_frame(frame), .o_frame_crc(frame_crc), .o_frame_cnt(frame_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("=== FAIL ===");
    $fatal(1, "timeout");
  endtask

  // One command from request to completion
  task automatic run_row(input stim_row_t row);
    int n;
    int frames_before;
    @(posedge clk);
    card_index   <= row.resp_index;
    card_content <= row.resp_content;
    card_corrupt <= row.corrupt;
    card_silent  <= row.silent;
    card_delay   <= row.delay;
    cmd_valid    <= 1'b1;
    cmd_index    <= row.index;
    cmd_arg      <= row.arg;
    n = 0;
    @(negedge clk);
    while (!cmd_ready) begin
      n++;
      if (n > READY_WAIT) report_timeout("o_cmd_ready");
      @(negedge clk);
    end
    frames_before = frame_cnt;
    n = 0;
    do begin
      @(posedge clk);
      cmd_valid <= (n == 4);  // Stray request while busy
      @(negedge clk);
      check_val("o_cmd_ready", 32'(cmd_ready), 32'h0);
      n++;
      if (n > DONE_WAIT) report_timeout("o_done");
    end while (!done);

    check_val("o_error_code", 32'(error_code), 32'(row.exp_err));
    check_val("o_acmd", 32'(acmd), 32'(row.exp_acmd));
    if (!row.silent) begin
      check_val("o_resp_content", resp_content, row.resp_content);
    end
    check_val("frame count", 32'(frame_cnt), 32'(frames_before + 1));
    check_val("frame start bit", 32'(frame[47]), 32'h0);
    check_val("frame transmitter bit", 32'(frame[46]), 32'h1);
    check_val("frame index", 32'(frame[45:40]), 32'(row.index));
    check_val("frame argument", frame[39:8], row.arg);
    check_val("frame crc7", 32'(frame[7:1]), 32'(frame_crc));
    check_val("frame stop bit", 32'(frame[0]), 32'h1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n        = 1'b0;
    cmd_valid    = 1'b0;
    cmd_index    = '0;
    cmd_arg      = '0;
    card_index   = '0;
    card_content = '0;
    card_corrupt = 1'b0;
    card_silent  = 1'b1;
    card_delay   = 0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_val("o_cmd_ready", 32'(cmd_ready), 32'h1);
    check_val("o_sd_cmd_oe", 32'(sd_cmd_oe), 32'h0);
    check_val("o_sd_cmd", 32'(sd_cmd_out), 32'h1);
    check_val("o_done", 32'(done), 32'h0);

    for (int i = 0; i < NUM_ROWS; i++) begin
      if (rows[i].delay < 0) begin
        rows[i].delay = $unsigned($random(seed)) % `SD_NCR_MAX;
      end
      run_row(rows[i]);
    end

    if (err_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
